// File: list.f
id_pkg.sv
mips_decoder.sv
operand_fwd.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - id_pkg.sv
  - mips_decoder.sv
  - operand_fwd.sv
  - id_ex_reg.sv
  - id_stage.sv
  - target: simulation
    files:
      - tb_id_stage.sv

// File: tb_id_stage.sv
`default_nettype none
`timescale 1ns/100ps

module tb_id_stage;

	localparam int n_imm_reps = 4;
	localparam int n_fwd      = 200;
	localparam int n_unknown  = 32;
	localparam int n_stream   = 200;
	// reset, funct sweep, immediates, forwarding, no-ops, stream, drains, margin
	localparam int max_cycles = 4 + 2 * 64 + 19 * n_imm_reps + n_fwd + 4 + n_unknown +
		n_stream + 6 * 3 + 50;

	// one row of the expected decode table
	typedef struct packed {
		logic [2:0]      sel;
		id_pkg::alu_op_t op;
		logic            we;
		logic            re1;
		logic            re2;
	} entry_t;

	logic             clk;
	logic             reset_n;
	id_pkg::inst_t    inst;
	id_pkg::wb_fwd_t  ex_fwd;
	id_pkg::wb_fwd_t  mem_fwd;
	id_pkg::word_t    rf1_data;
	id_pkg::word_t    rf2_data;
	id_pkg::rf_read_t rf1_req;
	id_pkg::rf_read_t rf2_req;
	id_pkg::id_ex_t   id_ex;

	id_pkg::decode_t  dec_exp;
	id_pkg::id_ex_t   exp_now;
	id_pkg::id_ex_t   exp_prev;
	logic             exp_valid = 1'b0;
	int               cycles    = 0;
	int               err_cnt   = 0;
	int               err_start = 0;
	int               tests_ok  = 0;
	int               tests_bad = 0;

	id_stage i_id_stage (
		.clk        (clk),
		.reset_n    (reset_n),
		.inst_i     (inst),
		.ex_fwd_i   (ex_fwd),
		.mem_fwd_i  (mem_fwd),
		.rf1_data_i (rf1_data),
		.rf2_data_i (rf2_data),
		.rf1_req_o  (rf1_req),
		.rf2_req_o  (rf2_req),
		.id_ex_o    (id_ex)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic id_pkg::decode_t ref_decode(input id_pkg::inst_t i);
		id_pkg::decode_t d;
		entry_t          e;
		logic            rtype;
		e     = '0;
		rtype = (i[31:26] == id_pkg::op_special) || (i[31:26] == id_pkg::op_special2);
		// flags are write enable, rs read, rt read
		case (i[31:26])
			id_pkg::op_ori:   e = {id_pkg::sel_logic, id_pkg::aluop_ori, 3'b110};
			id_pkg::op_andi:  e = {id_pkg::sel_logic, id_pkg::aluop_andi, 3'b110};
			id_pkg::op_xori:  e = {id_pkg::sel_logic, id_pkg::aluop_xori, 3'b110};
			id_pkg::op_lui:   e = {id_pkg::sel_logic, id_pkg::aluop_lui, 3'b110};
			id_pkg::op_pref:  e = {id_pkg::sel_nop, id_pkg::aluop_pref, 3'b000};
			id_pkg::op_addi:  e = {id_pkg::sel_arith, id_pkg::aluop_addi, 3'b110};
			id_pkg::op_addiu: e = {id_pkg::sel_arith, id_pkg::aluop_addiu, 3'b110};
			id_pkg::op_slti:  e = {id_pkg::sel_arith, id_pkg::aluop_slti, 3'b110};
			id_pkg::op_sltiu: e = {id_pkg::sel_arith, id_pkg::aluop_sltiu, 3'b110};
			id_pkg::op_special: begin
				case (i[5:0])
					id_pkg::funct_and:   e = {id_pkg::sel_logic, id_pkg::aluop_and, 3'b111};
					id_pkg::funct_or:    e = {id_pkg::sel_logic, id_pkg::aluop_or, 3'b111};
					id_pkg::funct_xor:   e = {id_pkg::sel_logic, id_pkg::aluop_xor, 3'b111};
					id_pkg::funct_nor:   e = {id_pkg::sel_logic, id_pkg::aluop_nor, 3'b111};
					id_pkg::funct_sll:   e = {id_pkg::sel_shift, id_pkg::aluop_sll, 3'b101};
					id_pkg::funct_srl:   e = {id_pkg::sel_shift, id_pkg::aluop_srl, 3'b101};
					id_pkg::funct_sra:   e = {id_pkg::sel_shift, id_pkg::aluop_sra, 3'b101};
					id_pkg::funct_sllv:  e = {id_pkg::sel_shift, id_pkg::aluop_sllv, 3'b111};
					id_pkg::funct_srlv:  e = {id_pkg::sel_shift, id_pkg::aluop_srlv, 3'b111};
					id_pkg::funct_srav:  e = {id_pkg::sel_shift, id_pkg::aluop_srav, 3'b111};
					id_pkg::funct_sync:  e = {id_pkg::sel_nop, id_pkg::aluop_sync, 3'b000};
					id_pkg::funct_movn:  e = {id_pkg::sel_move, id_pkg::aluop_movn, 3'b111};
					id_pkg::funct_movz:  e = {id_pkg::sel_move, id_pkg::aluop_movz, 3'b111};
					id_pkg::funct_mfhi:  e = {id_pkg::sel_move, id_pkg::aluop_mfhi, 3'b100};
					id_pkg::funct_mflo:  e = {id_pkg::sel_move, id_pkg::aluop_mflo, 3'b100};
					id_pkg::funct_mthi:  e = {id_pkg::sel_move, id_pkg::aluop_mthi, 3'b010};
					id_pkg::funct_mtlo:  e = {id_pkg::sel_move, id_pkg::aluop_mtlo, 3'b010};
					id_pkg::funct_add:   e = {id_pkg::sel_arith, id_pkg::aluop_add, 3'b111};
					id_pkg::funct_addu:  e = {id_pkg::sel_arith, id_pkg::aluop_addu, 3'b111};
					id_pkg::funct_sub:   e = {id_pkg::sel_arith, id_pkg::aluop_sub, 3'b111};
					id_pkg::funct_subu:  e = {id_pkg::sel_arith, id_pkg::aluop_subu, 3'b111};
					id_pkg::funct_slt:   e = {id_pkg::sel_arith, id_pkg::aluop_slt, 3'b111};
					id_pkg::funct_sltu:  e = {id_pkg::sel_arith, id_pkg::aluop_sltu, 3'b111};
					id_pkg::funct_mult:  e = {id_pkg::sel_arith, id_pkg::aluop_mult, 3'b011};
					id_pkg::funct_multu: e = {id_pkg::sel_arith, id_pkg::aluop_multu, 3'b011};
					id_pkg::funct_div:   e = {id_pkg::sel_arith, id_pkg::aluop_div, 3'b011};
					id_pkg::funct_divu:  e = {id_pkg::sel_arith, id_pkg::aluop_divu, 3'b011};
					default: ;
				endcase
			end
			id_pkg::op_special2: begin
				case (i[5:0])
					id_pkg::funct_clz:   e = {id_pkg::sel_arith, id_pkg::aluop_clz, 3'b110};
					id_pkg::funct_clo:   e = {id_pkg::sel_arith, id_pkg::aluop_clo, 3'b110};
					id_pkg::funct_mul:   e = {id_pkg::sel_arith, id_pkg::aluop_mul, 3'b111};
					id_pkg::funct_madd:  e = {id_pkg::sel_arith, id_pkg::aluop_madd, 3'b011};
					id_pkg::funct_maddu: e = {id_pkg::sel_arith, id_pkg::aluop_maddu, 3'b011};
					id_pkg::funct_msub:  e = {id_pkg::sel_arith, id_pkg::aluop_msub, 3'b011};
					id_pkg::funct_msubu: e = {id_pkg::sel_arith, id_pkg::aluop_msubu, 3'b011};
					default: ;
				endcase
			end
			default: ;
		endcase
		d          = '0;
		d.sel      = id_pkg::alu_sel_e'(e.sel);
		d.op       = e.op;
		d.we       = e.we;
		d.rf1.re   = e.re1;
		d.rf1.addr = i[25:21];
		d.rf2.re   = e.re2;
		d.rf2.addr = i[20:16];
		// an all-zero row is an unknown code with no destination
		if (e != '0) begin
			d.waddr = rtype ? i[15:11] : i[20:16];
		end
		if (i[31:26] inside {id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori,
			id_pkg::op_lui}) begin
			d.imm = {16'h0000, i[15:0]};
		end else if (i[31:26] inside {id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti,
			id_pkg::op_sltiu}) begin
			d.imm = {{16{i[15]}}, i[15:0]};
		end else if (e.sel == id_pkg::sel_shift && !e.re1) begin
			d.imm = {27'd0, i[10:6]};
		end
		return d;
	endfunction

	function automatic id_pkg::word_t pick_operand(input id_pkg::rf_read_t req,
		input id_pkg::word_t imm, input id_pkg::wb_fwd_t exf, input id_pkg::wb_fwd_t memf,
		input id_pkg::word_t rf);
		if (!req.re) begin
			return imm;
		end
		if (exf.we && exf.addr == req.addr) begin
			return exf.data;
		end
		if (memf.we && memf.addr == req.addr) begin
			return memf.data;
		end
		return rf;
	endfunction

	always_comb begin
		dec_exp       = ref_decode(inst);
		exp_now.sel   = dec_exp.sel;
		exp_now.op    = dec_exp.op;
		exp_now.op1   = pick_operand(dec_exp.rf1, dec_exp.imm, ex_fwd, mem_fwd, rf1_data);
		exp_now.op2   = pick_operand(dec_exp.rf2, dec_exp.imm, ex_fwd, mem_fwd, rf2_data);
		exp_now.we    = dec_exp.we;
		exp_now.waddr = dec_exp.waddr;
	end

	// expected bundle delayed by one edge, like the ID/EX register
	always @(posedge clk) begin
		exp_valid <= 1'b1;
		if (!reset_n) begin
			exp_prev <= '0;
		end else begin
			exp_prev <= exp_now;
		end
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > max_cycles) begin
			$display("run timed out after %0d cycles without reaching the end", cycles);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	a_bundle: assert property (@(posedge clk) exp_valid |-> id_ex == exp_prev)
		else begin
			err_cnt++;
			$display("Fail %0t: id_ex_o %h, expected %h", $time, $sampled(id_ex),
				$sampled(exp_prev));
		end

	a_reset: assert property (@(posedge clk) !reset_n |=> id_ex == '0)
		else begin
			err_cnt++;
			$display("Fail %0t: id_ex_o %h not cleared by reset", $time, $sampled(id_ex));
		end

	a_rf1: assert property (@(posedge clk) exp_valid |-> rf1_req == dec_exp.rf1)
		else begin
			err_cnt++;
			$display("Fail %0t: rf1_req_o %h, expected %h", $time, $sampled(rf1_req),
				$sampled(dec_exp.rf1));
		end

	a_rf2: assert property (@(posedge clk) exp_valid |-> rf2_req == dec_exp.rf2)
		else begin
			err_cnt++;
			$display("Fail %0t: rf2_req_o %h, expected %h", $time, $sampled(rf2_req),
				$sampled(dec_exp.rf2));
		end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	// aimed writes hit rs or rt so forwarding actually triggers
	function automatic id_pkg::wb_fwd_t make_fwd(input id_pkg::inst_t i, input bit aim);
		id_pkg::wb_fwd_t f;
		f.we   = ($urandom % 4) != 0;
		f.addr = aim ? ((($urandom % 2) != 0) ? i[25:21] : i[20:16]) : 5'($urandom);
		f.data = $urandom;
		return f;
	endfunction

	function automatic id_pkg::inst_t rand_inst(input bit known);
		id_pkg::inst_t   i;
		id_pkg::decode_t d;
		do begin
			i = $urandom;
			// bias toward the two function-code opcodes
			if (($urandom % 2) != 0) begin
				i[31:26] = (($urandom % 2) != 0) ? id_pkg::op_special : id_pkg::op_special2;
			end
			d = ref_decode(i);
		end while (known ? (d.sel == id_pkg::sel_nop) : (d.sel != id_pkg::sel_nop || d.op != 0));
		return i;
	endfunction

	task automatic apply(input id_pkg::inst_t i, input bit aim);
		id_pkg::wb_fwd_t exf;
		id_pkg::wb_fwd_t memf;
		exf  = make_fwd(i, aim);
		memf = make_fwd(i, aim);
		@(posedge clk);
		inst     <= i;
		ex_fwd   <= exf;
		mem_fwd  <= memf;
		rf1_data <= $urandom;
		rf2_data <= $urandom;
	endtask

	// wait until the last instruction has been checked
	task automatic finish_test(input string name);
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (err_cnt == err_start) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, err_cnt - err_start);
		end
		err_start = err_cnt;
	endtask

	initial begin
		id_pkg::opcode_t imm_ops [8];
		id_pkg::funct_t  shifts [3];
		imm_ops = '{id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori, id_pkg::op_lui,
			id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu};
		shifts  = '{id_pkg::funct_sll, id_pkg::funct_srl, id_pkg::funct_sra};
		void'($urandom(32'h702c6fa8));
		reset_n  = 1'b0;
		inst     = '0;
		ex_fwd   = '0;
		mem_fwd  = '0;
		rf1_data = '0;
		rf2_data = '0;

		repeat (4) @(posedge clk);
		reset_n <= 1'b1;
		finish_test("reset");

		// every function code, known or not
		for (int f = 0; f < 64; f++) begin
			apply({id_pkg::op_special, 20'($urandom), 6'(f)}, 1'b0);
			apply({id_pkg::op_special2, 20'($urandom), 6'(f)}, 1'b0);
		end
		finish_test("r-type decode");

		for (int r = 0; r < n_imm_reps; r++) begin
			for (int k = 0; k < 8; k++) begin
				apply({imm_ops[k], 10'($urandom), 1'b0, 15'($urandom)}, 1'b1);
				apply({imm_ops[k], 10'($urandom), 1'b1, 15'($urandom)}, 1'b1);
			end
			for (int k = 0; k < 3; k++) begin
				apply({id_pkg::op_special, 15'($urandom), 5'($urandom), shifts[k]}, 1'b1);
			end
		end
		finish_test("immediate forms");

		for (int n = 0; n < n_fwd; n++) begin
			apply(rand_inst(1'b1), 1'b1);
		end
		finish_test("forwarding priority");

		apply({id_pkg::op_pref, 26'($urandom)}, 1'b1);
		apply({id_pkg::op_pref, 26'($urandom)}, 1'b1);
		apply({id_pkg::op_special, 20'($urandom), id_pkg::funct_sync}, 1'b1);
		apply({id_pkg::op_special, 20'($urandom), id_pkg::funct_sync}, 1'b1);
		for (int n = 0; n < n_unknown; n++) begin
			apply(rand_inst(1'b0), 1'b1);
		end
		finish_test("non-writing and unknown codes");

		for (int n = 0; n < n_stream; n++) begin
			apply(rand_inst(1'b1), 1'b0);
		end
		finish_test("back-to-back flow");

		$display("%0d tests passed, %0d tests failed, %0d check errors", tests_ok, tests_bad,
			err_cnt);
		if (err_cnt == 0 && tests_bad == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: id_stage.sv
`default_nettype none
`timescale 1ns/100ps

module id_stage (
	input  wire                   clk,
	input  wire                   reset_n,
	input  wire id_pkg::inst_t    inst_i,
	input  wire id_pkg::wb_fwd_t  ex_fwd_i,
	input  wire id_pkg::wb_fwd_t  mem_fwd_i,
	input  wire id_pkg::word_t    rf1_data_i,
	input  wire id_pkg::word_t    rf2_data_i,
	output wire id_pkg::rf_read_t rf1_req_o,
	output wire id_pkg::rf_read_t rf2_req_o,
	output wire id_pkg::id_ex_t   id_ex_o
);

	id_pkg::decode_t dec;
	id_pkg::word_t   op1;
	id_pkg::word_t   op2;

	mips_decoder u_dec (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	// register file is read in the same cycle
	assign rf1_req_o = dec.rf1;
	assign rf2_req_o = dec.rf2;

	////////////////////////////////////////////////////////////////////////////
	// operand selection, one per source port
	////////////////////////////////////////////////////////////////////////////
	operand_fwd u_fwd1 (
		.req_i     (dec.rf1),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.rf_data_i (rf1_data_i),
		.operand_o (op1)
	);

	operand_fwd u_fwd2 (
		.req_i     (dec.rf2),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.rf_data_i (rf2_data_i),
		.operand_o (op2)
	);

	// hand-off to execute
	id_ex_reg u_id_ex (
		.clk     (clk),
		.reset_n (reset_n),
		.dec_i   (dec),
		.op1_i   (op1),
		.op2_i   (op2),
		.id_ex_o (id_ex_o)
	);

endmodule

`default_nettype wire

// File: id_ex_reg.sv
`default_nettype none
`timescale 1ns/100ps

module id_ex_reg (
	input  wire                  clk,
	input  wire                  reset_n,
	input  wire id_pkg::decode_t dec_i,
	input  wire id_pkg::word_t   op1_i,
	input  wire id_pkg::word_t   op2_i,
	output id_pkg::id_ex_t       id_ex_o
);

	id_pkg::id_ex_t id_ex_d;

	// execute bundle from the decode result and resolved operands
	always_comb begin
		id_ex_d.sel   = dec_i.sel;
		id_ex_d.op    = dec_i.op;
		id_ex_d.op1   = op1_i;
		id_ex_d.op2   = op2_i;
		id_ex_d.we    = dec_i.we;
		id_ex_d.waddr = dec_i.waddr;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			id_ex_o <= '0;
		end else begin
			id_ex_o <= id_ex_d;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bundle checks
	////////////////////////////////////////////////////////////////////////////
	// decoder must only ever hand over a known unit group
	a_sel_legal: assert property (@(posedge clk) disable iff (!reset_n)
		id_ex_o.sel inside {id_pkg::sel_nop, id_pkg::sel_logic, id_pkg::sel_shift,
			id_pkg::sel_move, id_pkg::sel_arith});

	// a writing instruction always goes to some ALU unit
	a_we_not_nop: assert property (@(posedge clk) disable iff (!reset_n)
		id_ex_o.we |-> id_ex_o.sel != id_pkg::sel_nop);

	// reset flushes the stage on the next edge
	a_reset_clear: assert property (@(posedge clk)
		!reset_n |=> id_ex_o == '0);

endmodule

`default_nettype wire

// File: operand_fwd.sv
`default_nettype none
`timescale 1ns/100ps

module operand_fwd (
	input  wire id_pkg::rf_read_t req_i,
	input  wire id_pkg::word_t    imm_i,
	input  wire id_pkg::wb_fwd_t  ex_fwd_i,
	input  wire id_pkg::wb_fwd_t  mem_fwd_i,
	input  wire id_pkg::word_t    rf_data_i,
	output id_pkg::word_t         operand_o
);

	logic ex_hit;
	logic mem_hit;

	// a later stage is about to write the register this port reads
	assign ex_hit  = req_i.re && ex_fwd_i.we && (ex_fwd_i.addr == req_i.addr);
	assign mem_hit = req_i.re && mem_fwd_i.we && (mem_fwd_i.addr == req_i.addr);

	// youngest result wins, so execute beats memory
	always_comb begin
		if (ex_hit) begin
			operand_o = ex_fwd_i.data;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.data;
		end else if (req_i.re) begin
			operand_o = rf_data_i;
		end else begin
			// port not reading a register carries the immediate
			operand_o = imm_i;
		end
	end

endmodule

`default_nettype wire

// File: mips_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module mips_decoder (
	input  wire id_pkg::inst_t inst_i,
	output id_pkg::decode_t    dec_o
);

	id_pkg::opcode_t   opcode;
	id_pkg::funct_t    funct;
	id_pkg::reg_addr_t rs;
	id_pkg::reg_addr_t rt;
	id_pkg::reg_addr_t rd;
	logic [4:0]        shamt;
	logic [15:0]       imm16;
	id_pkg::word_t     imm;

	// instruction fields
	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	// one row of the decode table, addresses and immediate are added later
	function automatic id_pkg::decode_t row(
		input id_pkg::alu_sel_e  sel,
		input id_pkg::alu_op_t   op,
		input logic              we,
		input logic              re1,
		input logic              re2,
		input id_pkg::reg_addr_t dst
	);
		id_pkg::decode_t d;
		d        = '0;
		d.sel    = sel;
		d.op     = op;
		d.we     = we;
		d.waddr  = dst;
		d.rf1.re = re1;
		d.rf2.re = re2;
		return d;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// immediate generation
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		imm = '0;
		case (opcode)
			id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori, id_pkg::op_lui: begin
				imm = {16'h0000, imm16};
			end
			id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu: begin
				imm = {{16{imm16[15]}}, imm16};
			end
			id_pkg::op_special: begin
				// constant shifts take shamt in place of rs
				if (funct == id_pkg::funct_sll || funct == id_pkg::funct_srl ||
					funct == id_pkg::funct_sra) begin
					imm = {27'd0, shamt};
				end
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// decode table
	////////////////////////////////////////////////////////////////////////////
	// row arguments: selector, op, write enable, rs read, rt read, destination
	always_comb begin
		// anything not listed stays a no-op
		dec_o = row(id_pkg::sel_nop, id_pkg::aluop_nop, 1'b0, 1'b0, 1'b0, '0);
		case (opcode)
			// immediate logic group
			id_pkg::op_ori:
				dec_o = row(id_pkg::sel_logic, id_pkg::aluop_ori, 1'b1, 1'b1, 1'b0, rt);
			id_pkg::op_andi:
				dec_o = row(id_pkg::sel_logic, id_pkg::aluop_andi, 1'b1, 1'b1, 1'b0, rt);
			id_pkg::op_xori:
				dec_o = row(id_pkg::sel_logic, id_pkg::aluop_xori, 1'b1, 1'b1, 1'b0, rt);
			id_pkg::op_lui:
				dec_o = row(id_pkg::sel_logic, id_pkg::aluop_lui, 1'b1, 1'b1, 1'b0, rt);
			id_pkg::op_pref:
				dec_o = row(id_pkg::sel_nop, id_pkg::aluop_pref, 1'b0, 1'b0, 1'b0, rt);
			// immediate arithmetic group
			id_pkg::op_addi:
				dec_o = row(id_pkg::sel_arith, id_pkg::aluop_addi, 1'b1, 1'b1, 1'b0, rt);
			id_pkg::op_addiu:
				dec_o = row(id_pkg::sel_arith, id_pkg::aluop_addiu, 1'b1, 1'b1, 1'b0, rt);
			id_pkg::op_slti:
				dec_o = row(id_pkg::sel_arith, id_pkg::aluop_slti, 1'b1, 1'b1, 1'b0, rt);
			id_pkg::op_sltiu:
				dec_o = row(id_pkg::sel_arith, id_pkg::aluop_sltiu, 1'b1, 1'b1, 1'b0, rt);

			id_pkg::op_special: begin
				case (funct)
					id_pkg::funct_and:
						dec_o = row(id_pkg::sel_logic, id_pkg::aluop_and, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_or:
						dec_o = row(id_pkg::sel_logic, id_pkg::aluop_or, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_xor:
						dec_o = row(id_pkg::sel_logic, id_pkg::aluop_xor, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_nor:
						dec_o = row(id_pkg::sel_logic, id_pkg::aluop_nor, 1'b1, 1'b1, 1'b1, rd);
					// constant shifts, rs port carries shamt
					id_pkg::funct_sll:
						dec_o = row(id_pkg::sel_shift, id_pkg::aluop_sll, 1'b1, 1'b0, 1'b1, rd);
					id_pkg::funct_srl:
						dec_o = row(id_pkg::sel_shift, id_pkg::aluop_srl, 1'b1, 1'b0, 1'b1, rd);
					id_pkg::funct_sra:
						dec_o = row(id_pkg::sel_shift, id_pkg::aluop_sra, 1'b1, 1'b0, 1'b1, rd);
					id_pkg::funct_sllv:
						dec_o = row(id_pkg::sel_shift, id_pkg::aluop_sllv, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_srlv:
						dec_o = row(id_pkg::sel_shift, id_pkg::aluop_srlv, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_srav:
						dec_o = row(id_pkg::sel_shift, id_pkg::aluop_srav, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_sync:
						dec_o = row(id_pkg::sel_nop, id_pkg::aluop_sync, 1'b0, 1'b0, 1'b0, rd);
					// moves and hi/lo access
					id_pkg::funct_movn:
						dec_o = row(id_pkg::sel_move, id_pkg::aluop_movn, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_movz:
						dec_o = row(id_pkg::sel_move, id_pkg::aluop_movz, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_mfhi:
						dec_o = row(id_pkg::sel_move, id_pkg::aluop_mfhi, 1'b1, 1'b0, 1'b0, rd);
					id_pkg::funct_mflo:
						dec_o = row(id_pkg::sel_move, id_pkg::aluop_mflo, 1'b1, 1'b0, 1'b0, rd);
					id_pkg::funct_mthi:
						dec_o = row(id_pkg::sel_move, id_pkg::aluop_mthi, 1'b0, 1'b1, 1'b0, rd);
					id_pkg::funct_mtlo:
						dec_o = row(id_pkg::sel_move, id_pkg::aluop_mtlo, 1'b0, 1'b1, 1'b0, rd);
					// arithmetic
					id_pkg::funct_add:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_add, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_addu:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_addu, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_sub:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_sub, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_subu:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_subu, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_slt:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_slt, 1'b1, 1'b1, 1'b1, rd);
					id_pkg::funct_sltu:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_sltu, 1'b1, 1'b1, 1'b1, rd);
					// mult/div write hi/lo, never the register file
					id_pkg::funct_mult:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_mult, 1'b0, 1'b1, 1'b1, rd);
					id_pkg::funct_multu:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_multu, 1'b0, 1'b1, 1'b1, rd);
					id_pkg::funct_div:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_div, 1'b0, 1'b1, 1'b1, rd);
					id_pkg::funct_divu:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_divu, 1'b0, 1'b1, 1'b1, rd);
					default: ;
				endcase
			end

			id_pkg::op_special2: begin
				case (funct)
					id_pkg::funct_clz:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_clz, 1'b1, 1'b1, 1'b0, rd);
					id_pkg::funct_clo:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_clo, 1'b1, 1'b1, 1'b0, rd);
					id_pkg::funct_mul:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_mul, 1'b1, 1'b1, 1'b1, rd);
					// accumulate into hi/lo
					id_pkg::funct_madd:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_madd, 1'b0, 1'b1, 1'b1, rd);
					id_pkg::funct_maddu:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_maddu, 1'b0, 1'b1, 1'b1, rd);
					id_pkg::funct_msub:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_msub, 1'b0, 1'b1, 1'b1, rd);
					id_pkg::funct_msubu:
						dec_o = row(id_pkg::sel_arith, id_pkg::aluop_msubu, 1'b0, 1'b1, 1'b1, rd);
					default: ;
				endcase
			end
			default: ;
		endcase

		// read addresses follow the instruction whatever the enables
		dec_o.rf1.addr = rs;
		dec_o.rf2.addr = rt;
		dec_o.imm      = imm;
	end

endmodule

`default_nettype wire

// File: id_pkg.sv
`default_nettype none

package id_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [7:0]  alu_op_t;

	// ALU unit groups seen by execute
	typedef enum logic [2:0] {
		sel_nop   = 3'b000,
		sel_logic = 3'b001,
		sel_shift = 3'b010,
		sel_move  = 3'b011,
		sel_arith = 3'b100
	} alu_sel_e;

	////////////////////////////////////////////////////////////////////////////
	// primary opcodes
	////////////////////////////////////////////////////////////////////////////
	localparam opcode_t op_special  = 6'b000000;
	localparam opcode_t op_special2 = 6'b011100;
	localparam opcode_t op_ori      = 6'b001101;
	localparam opcode_t op_andi     = 6'b001100;
	localparam opcode_t op_xori     = 6'b001110;
	localparam opcode_t op_lui      = 6'b001111;
	localparam opcode_t op_pref     = 6'b110011;
	localparam opcode_t op_addi     = 6'b001000;
	localparam opcode_t op_addiu    = 6'b001001;
	localparam opcode_t op_slti     = 6'b001010;
	localparam opcode_t op_sltiu    = 6'b001011;

	////////////////////////////////////////////////////////////////////////////
	// function codes, SPECIAL then SPECIAL2
	////////////////////////////////////////////////////////////////////////////
	localparam funct_t funct_and   = 6'b100100;
	localparam funct_t funct_or    = 6'b100101;
	localparam funct_t funct_xor   = 6'b100110;
	localparam funct_t funct_nor   = 6'b100111;
	localparam funct_t funct_sll   = 6'b000000;
	localparam funct_t funct_srl   = 6'b000010;
	localparam funct_t funct_sra   = 6'b000011;
	localparam funct_t funct_sllv  = 6'b000100;
	localparam funct_t funct_srlv  = 6'b000110;
	localparam funct_t funct_srav  = 6'b000111;
	localparam funct_t funct_sync  = 6'b001111;
	localparam funct_t funct_movn  = 6'b001011;
	localparam funct_t funct_movz  = 6'b001010;
	localparam funct_t funct_mfhi  = 6'b010000;
	localparam funct_t funct_mflo  = 6'b010010;
	localparam funct_t funct_mthi  = 6'b010001;
	localparam funct_t funct_mtlo  = 6'b010011;
	localparam funct_t funct_add   = 6'b100000;
	localparam funct_t funct_addu  = 6'b100001;
	localparam funct_t funct_sub   = 6'b100010;
	localparam funct_t funct_subu  = 6'b100011;
	localparam funct_t funct_slt   = 6'b101010;
	localparam funct_t funct_sltu  = 6'b101011;
	localparam funct_t funct_mult  = 6'b011000;
	localparam funct_t funct_multu = 6'b011001;
	localparam funct_t funct_div   = 6'b011010;
	localparam funct_t funct_divu  = 6'b011011;

	localparam funct_t funct_clz   = 6'b100000;
	localparam funct_t funct_clo   = 6'b100001;
	localparam funct_t funct_mul   = 6'b000010;
	localparam funct_t funct_madd  = 6'b000000;
	localparam funct_t funct_maddu = 6'b000001;
	localparam funct_t funct_msub  = 6'b000100;
	localparam funct_t funct_msubu = 6'b000101;

	////////////////////////////////////////////////////////////////////////////
	// ALU operation codes
	////////////////////////////////////////////////////////////////////////////
	// codes repeat across groups, the selector tells them apart
	localparam alu_op_t aluop_nop   = 8'h00;
	localparam alu_op_t aluop_ori   = 8'h0d;
	localparam alu_op_t aluop_andi  = 8'h0c;
	localparam alu_op_t aluop_xori  = 8'h0e;
	localparam alu_op_t aluop_lui   = 8'h0f;
	localparam alu_op_t aluop_pref  = 8'h33;
	localparam alu_op_t aluop_addi  = 8'h08;
	localparam alu_op_t aluop_addiu = 8'h09;
	localparam alu_op_t aluop_slti  = 8'h0a;
	localparam alu_op_t aluop_sltiu = 8'h0b;
	localparam alu_op_t aluop_and   = 8'h24;
	localparam alu_op_t aluop_or    = 8'h25;
	localparam alu_op_t aluop_xor   = 8'h26;
	localparam alu_op_t aluop_nor   = 8'h27;
	localparam alu_op_t aluop_sll   = 8'h00;
	localparam alu_op_t aluop_srl   = 8'h02;
	localparam alu_op_t aluop_sra   = 8'h03;
	localparam alu_op_t aluop_sllv  = 8'h04;
	localparam alu_op_t aluop_srlv  = 8'h06;
	localparam alu_op_t aluop_srav  = 8'h07;
	localparam alu_op_t aluop_sync  = 8'h0f;
	localparam alu_op_t aluop_movn  = 8'h0b;
	localparam alu_op_t aluop_movz  = 8'h0a;
	localparam alu_op_t aluop_mfhi  = 8'h10;
	localparam alu_op_t aluop_mflo  = 8'h12;
	localparam alu_op_t aluop_mthi  = 8'h11;
	localparam alu_op_t aluop_mtlo  = 8'h13;
	localparam alu_op_t aluop_add   = 8'h20;
	localparam alu_op_t aluop_addu  = 8'h21;
	localparam alu_op_t aluop_sub   = 8'h22;
	localparam alu_op_t aluop_subu  = 8'h23;
	localparam alu_op_t aluop_slt   = 8'h2a;
	localparam alu_op_t aluop_sltu  = 8'h2b;
	localparam alu_op_t aluop_mult  = 8'h18;
	localparam alu_op_t aluop_multu = 8'h19;
	localparam alu_op_t aluop_div   = 8'h1a;
	localparam alu_op_t aluop_divu  = 8'h1b;
	localparam alu_op_t aluop_clz   = 8'he0;
	localparam alu_op_t aluop_clo   = 8'he1;
	localparam alu_op_t aluop_mul   = 8'h02;
	localparam alu_op_t aluop_madd  = 8'hc0;
	localparam alu_op_t aluop_maddu = 8'hc1;
	localparam alu_op_t aluop_msub  = 8'hc4;
	localparam alu_op_t aluop_msubu = 8'hc5;

	////////////////////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic      re;
		reg_addr_t addr;
	} rf_read_t;

	// one write from a later stage, used for forwarding
	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} wb_fwd_t;

	typedef struct packed {
		alu_sel_e  sel;
		alu_op_t   op;
		logic      we;
		reg_addr_t waddr;
		rf_read_t  rf1;
		rf_read_t  rf2;
		word_t     imm;
	} decode_t;

	typedef struct packed {
		alu_sel_e  sel;
		alu_op_t   op;
		word_t     op1;
		word_t     op2;
		logic      we;
		reg_addr_t waddr;
	} id_ex_t;

endpackage

`default_nettype wire
